//--- source/uce_settings.svh
`ifndef UCE_SETTINGS_SVH
`define UCE_SETTINGS_SVH

// physical address bits
`define UCE_PADDR_WIDTH 32

// one block is also one fill beat
`define UCE_BLOCK_WIDTH 128

// uncached data width
`define UCE_DWORD_WIDTH 64

// cache geometry
`define UCE_SETS 8
`define UCE_ASSOC 2

`define UCE_LCE_ID_WIDTH 4

// memory commands allowed in flight
`define UCE_MAX_CREDITS 4

`endif

//--- source/uce_pkg.sv
`include "uce_settings.svh"

package uce_pkg;

  // derived field widths
  localparam int offset_width = $clog2(`UCE_BLOCK_WIDTH / 8);
  localparam int index_width = $clog2(`UCE_SETS);
  localparam int way_width = (`UCE_ASSOC > 1) ? $clog2(`UCE_ASSOC) : 1;
  localparam int tag_width = `UCE_PADDR_WIDTH - index_width - offset_width;

  // size code of a whole block, log2 of its bytes
  localparam logic [2:0] block_msg_size = 3'(offset_width);

  typedef logic [`UCE_PADDR_WIDTH-1:0] paddr_t;
  typedef logic [`UCE_BLOCK_WIDTH-1:0] block_t;
  typedef logic [`UCE_DWORD_WIDTH-1:0] dword_t;
  typedef logic [index_width-1:0] index_t;
  typedef logic [way_width-1:0] way_t;
  typedef logic [tag_width-1:0] tag_t;
  typedef logic [`UCE_LCE_ID_WIDTH-1:0] lce_id_t;
  typedef logic [$clog2(`UCE_MAX_CREDITS+1)-1:0] credit_t;

  typedef enum logic [1:0] {e_miss_load, e_miss_store, e_uc_load, e_uc_store} cache_req_type_e;

  typedef struct packed {
    cache_req_type_e msg_type;
    paddr_t addr;
    logic [2:0] size;
    dword_t data;
  } cache_req_s;

  typedef struct packed {
    way_t repl_way;
    logic dirty;
  } cache_metadata_s;

  typedef enum logic [1:0] {e_tag_clear, e_tag_read, e_tag_set_tag} tag_op_e;
  typedef enum logic [1:0] {e_data_read, e_data_write, e_data_uncached} data_op_e;
  typedef enum logic [0:0] {e_stat_clear, e_stat_clear_dirty} stat_op_e;

  typedef struct packed {
    tag_op_e opcode;
    index_t index;
    way_t way;
    tag_t tag;
  } tag_mem_pkt_s;

  typedef struct packed {
    data_op_e opcode;
    index_t index;
    way_t way;
    block_t data;
  } data_mem_pkt_s;

  typedef struct packed {
    stat_op_e opcode;
    index_t index;
    way_t way;
  } stat_mem_pkt_s;

  typedef enum logic [1:0] {e_mem_rd, e_mem_wr, e_mem_uc_rd, e_mem_uc_wr} mem_msg_type_e;

  // shared by memory commands and responses
  typedef struct packed {
    mem_msg_type_e msg_type;
    paddr_t addr;
    logic [2:0] size;
    lce_id_t lce_id;
    way_t way;
    block_t data;
  } mem_msg_s;

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_ready,
    e_send,
    e_evict,
    e_fill_wait,
    e_writeback,
    e_uc_wait
  } uce_state_e;

endpackage

//--- source/uce_request_latch.sv
`timescale 1ns/1ns

module uce_request_latch
  import uce_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  cache_req_s      cache_req_i,
  input  cache_metadata_s cache_metadata_i,
  input  logic            cache_metadata_v_i,
  input  logic            accept_i,
  input  logic            complete_i,
  output cache_req_s      req_o,
  output cache_metadata_s metadata_o,
  output logic            metadata_v_o
);

  cache_req_s req_r;
  cache_metadata_s metadata_r;
  logic metadata_v_r;
  logic req_v_r;

  always_ff @(posedge clk_i)
  begin
    if (accept_i)
      req_r <= cache_req_i;
    if (cache_metadata_v_i)
      metadata_r <= cache_metadata_i;
  end

  // metadata may arrive in the accept cycle, so a set wins over the clear
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      metadata_v_r <= 1'b0;
      req_v_r <= 1'b0;
    end
    else
    begin
      if (cache_metadata_v_i)
        metadata_v_r <= 1'b1;
      else if (accept_i)
        metadata_v_r <= 1'b0;

      if (accept_i)
        req_v_r <= 1'b1;
      else if (complete_i)
        req_v_r <= 1'b0;
    end
  end

  assign req_o = req_r;
  assign metadata_o = metadata_r;
  assign metadata_v_o = metadata_v_r;

  a_no_accept_on_complete: assert property (@(posedge clk_i) disable iff (reset_i)
    !(accept_i && complete_i));

  // a completion always belongs to an earlier accepted request
  a_complete_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    complete_i |-> req_v_r);

endmodule

//--- source/uce_credit_counter.sv
`timescale 1ns/1ns

`include "uce_settings.svh"

module uce_credit_counter
  import uce_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cmd_sent_i,
  input  logic resp_consumed_i,
  output logic full_o,
  output logic empty_o
);

  localparam credit_t max_credits = credit_t'(`UCE_MAX_CREDITS);

  credit_t count_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (cmd_sent_i && !resp_consumed_i)
      count_r <= count_r + credit_t'(1);
    else if (resp_consumed_i && !cmd_sent_i)
      count_r <= count_r - credit_t'(1);
  end

  assign full_o = (count_r == max_credits);
  assign empty_o = (count_r == '0);

  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_sent_i && !resp_consumed_i) |-> (count_r != max_credits));

  // a response without a command in flight means a stray memory reply
  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_consumed_i && !cmd_sent_i) |-> (count_r != '0));

endmodule

//--- source/uce_dirty_capture.sv
`timescale 1ns/1ns

module uce_dirty_capture
  import uce_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   evict_i,
  input  block_t data_mem_i,
  input  tag_t   tag_mem_i,
  output block_t victim_data_o,
  output tag_t   victim_tag_o,
  output logic   victim_v_o
);

  logic evict_r;
  logic victim_v_r;
  block_t victim_data_r;
  tag_t victim_tag_r;

  // read data from the cache memories shows up one cycle after the read
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      evict_r <= 1'b0;
      victim_v_r <= 1'b0;
    end
    else
    begin
      evict_r <= evict_i;
      if (evict_i)
        victim_v_r <= 1'b0;
      else if (evict_r)
        victim_v_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (evict_r)
    begin
      victim_data_r <= data_mem_i;
      victim_tag_r <= tag_mem_i;
    end
  end

  assign victim_data_o = victim_data_r;
  assign victim_tag_o = victim_tag_r;
  assign victim_v_o = victim_v_r;

endmodule

//--- source/uce_control.sv
`timescale 1ns/1ns

`include "uce_settings.svh"

module uce_control
  import uce_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  lce_id_t         lce_id_i,

  input  cache_req_s      cache_req_i,
  input  logic            cache_req_v_i,
  output logic            cache_req_yumi_o,
  output logic            cache_req_busy_o,
  output logic            cache_req_complete_o,

  input  cache_req_s      held_req_i,
  input  cache_metadata_s held_metadata_i,
  input  logic            held_metadata_v_i,
  output logic            accept_o,

  output logic            evict_o,
  input  block_t          victim_data_i,
  input  tag_t            victim_tag_i,
  input  logic            victim_v_i,

  input  logic            credits_full_i,

  output tag_mem_pkt_s    tag_mem_pkt_o,
  output logic            tag_mem_pkt_v_o,
  output data_mem_pkt_s   data_mem_pkt_o,
  output logic            data_mem_pkt_v_o,
  output stat_mem_pkt_s   stat_mem_pkt_o,
  output logic            stat_mem_pkt_v_o,

  output mem_msg_s        mem_cmd_o,
  output logic            mem_cmd_v_o,
  input  logic            mem_cmd_ready_i,
  input  mem_msg_s        mem_resp_i,
  input  logic            mem_resp_v_i,
  output logic            mem_resp_yumi_o
);

  localparam int dwords_per_block = $bits(block_t) / $bits(dword_t);

  uce_state_e state_r, state_n;
  index_t clear_index_r;
  logic resp_yumi_lo;

  wire uc_store_li = (cache_req_i.msg_type == e_uc_store);
  wire held_miss = held_req_i.msg_type inside {e_miss_load, e_miss_store};
  wire load_resp_v = mem_resp_v_i && mem_resp_i.msg_type inside {e_mem_rd, e_mem_uc_rd};
  wire store_resp_v = mem_resp_v_i && mem_resp_i.msg_type inside {e_mem_wr, e_mem_uc_wr};

  wire index_t req_index = held_req_i.addr[offset_width +: index_width];
  wire index_t resp_index = mem_resp_i.addr[offset_width +: index_width];
  wire tag_t resp_tag = mem_resp_i.addr[offset_width + index_width +: tag_width];

  // write acks are drained in any state
  assign mem_resp_yumi_o = resp_yumi_lo || store_resp_v;
  assign cache_req_busy_o = (state_r == e_reset) || (state_r == e_clear) || credits_full_i;
  assign accept_o = cache_req_yumi_o;

  always_comb
  begin
    state_n = state_r;
    cache_req_yumi_o = 1'b0;
    cache_req_complete_o = 1'b0;
    evict_o = 1'b0;
    resp_yumi_lo = 1'b0;
    tag_mem_pkt_o = '0;
    tag_mem_pkt_v_o = 1'b0;
    data_mem_pkt_o = '0;
    data_mem_pkt_v_o = 1'b0;
    stat_mem_pkt_o = '0;
    stat_mem_pkt_v_o = 1'b0;
    mem_cmd_o = '0;
    mem_cmd_o.lce_id = lce_id_i;
    mem_cmd_v_o = 1'b0;

    unique case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_mem_pkt_o.opcode = e_tag_clear;
        tag_mem_pkt_o.index = clear_index_r;
        tag_mem_pkt_v_o = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_clear;
        stat_mem_pkt_o.index = clear_index_r;
        stat_mem_pkt_v_o = 1'b1;
        if (clear_index_r == index_t'(`UCE_SETS - 1))
          state_n = e_ready;
      end
      e_ready:
      begin
        // only a store needs the memory port right now
        cache_req_yumi_o = cache_req_v_i && !credits_full_i && (mem_cmd_ready_i || !uc_store_li);
        if (uc_store_li)
        begin
          mem_cmd_o.msg_type = e_mem_uc_wr;
          mem_cmd_o.addr = cache_req_i.addr;
          mem_cmd_o.size = cache_req_i.size;
          mem_cmd_o.data = block_t'(cache_req_i.data);
          mem_cmd_v_o = cache_req_yumi_o;
        end
        else if (cache_req_yumi_o)
          state_n = e_send;
      end
      e_send:
      begin
        if (held_miss)
        begin
          mem_cmd_o.msg_type = e_mem_rd;
          mem_cmd_o.addr = {held_req_i.addr[`UCE_PADDR_WIDTH-1:offset_width], {offset_width{1'b0}}};
          mem_cmd_o.size = block_msg_size;
          mem_cmd_o.way = held_metadata_i.repl_way;
          mem_cmd_v_o = mem_cmd_ready_i && held_metadata_v_i;
          if (mem_cmd_v_o)
            state_n = held_metadata_i.dirty ? e_evict : e_fill_wait;
        end
        else
        begin
          mem_cmd_o.msg_type = e_mem_uc_rd;
          mem_cmd_o.addr = held_req_i.addr;
          mem_cmd_o.size = held_req_i.size;
          mem_cmd_v_o = mem_cmd_ready_i;
          if (mem_cmd_v_o)
            state_n = e_uc_wait;
        end
      end
      e_evict:
      begin
        data_mem_pkt_o.opcode = e_data_read;
        data_mem_pkt_o.index = req_index;
        data_mem_pkt_o.way = held_metadata_i.repl_way;
        data_mem_pkt_v_o = 1'b1;
        tag_mem_pkt_o.opcode = e_tag_read;
        tag_mem_pkt_o.index = req_index;
        tag_mem_pkt_o.way = held_metadata_i.repl_way;
        tag_mem_pkt_v_o = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_clear_dirty;
        stat_mem_pkt_o.index = req_index;
        stat_mem_pkt_o.way = held_metadata_i.repl_way;
        stat_mem_pkt_v_o = 1'b1;
        evict_o = 1'b1;
        state_n = e_fill_wait;
      end
      e_fill_wait:
      begin
        // set tag fills the line as modified, no coherence traffic follows
        tag_mem_pkt_o.opcode = e_tag_set_tag;
        tag_mem_pkt_o.index = resp_index;
        tag_mem_pkt_o.way = mem_resp_i.way;
        tag_mem_pkt_o.tag = resp_tag;
        tag_mem_pkt_v_o = load_resp_v;
        data_mem_pkt_o.opcode = e_data_write;
        data_mem_pkt_o.index = resp_index;
        data_mem_pkt_o.way = mem_resp_i.way;
        data_mem_pkt_o.data = mem_resp_i.data;
        data_mem_pkt_v_o = load_resp_v;
        resp_yumi_lo = load_resp_v;
        cache_req_complete_o = load_resp_v;
        if (load_resp_v)
          state_n = held_metadata_i.dirty ? e_writeback : e_ready;
      end
      e_writeback:
      begin
        mem_cmd_o.msg_type = e_mem_wr;
        mem_cmd_o.addr = {victim_tag_i, req_index, {offset_width{1'b0}}};
        mem_cmd_o.size = block_msg_size;
        mem_cmd_o.way = held_metadata_i.repl_way;
        mem_cmd_o.data = victim_data_i;
        mem_cmd_v_o = mem_cmd_ready_i && victim_v_i;
        if (mem_cmd_v_o)
          state_n = e_ready;
      end
      e_uc_wait:
      begin
        data_mem_pkt_o.opcode = e_data_uncached;
        data_mem_pkt_o.data = {dwords_per_block{mem_resp_i.data[0 +: $bits(dword_t)]}};
        data_mem_pkt_v_o = load_resp_v;
        resp_yumi_lo = load_resp_v;
        cache_req_complete_o = load_resp_v;
        if (load_resp_v)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      clear_index_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (state_r == e_clear)
        clear_index_r <= clear_index_r + index_t'(1);
    end
  end

  a_cmd_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o |-> mem_cmd_ready_i);

endmodule

//--- source/uce.sv
`timescale 1ns/1ns

module uce
  import uce_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  lce_id_t         lce_id_i,

  input  cache_req_s      cache_req_i,
  input  logic            cache_req_v_i,
  output logic            cache_req_yumi_o,
  output logic            cache_req_busy_o,
  input  cache_metadata_s cache_metadata_i,
  input  logic            cache_metadata_v_i,
  output logic            cache_req_complete_o,
  output logic            cache_req_credits_full_o,
  output logic            cache_req_credits_empty_o,

  output tag_mem_pkt_s    tag_mem_pkt_o,
  output logic            tag_mem_pkt_v_o,
  input  tag_t            tag_mem_i,
  output data_mem_pkt_s   data_mem_pkt_o,
  output logic            data_mem_pkt_v_o,
  input  block_t          data_mem_i,
  output stat_mem_pkt_s   stat_mem_pkt_o,
  output logic            stat_mem_pkt_v_o,

  output mem_msg_s        mem_cmd_o,
  output logic            mem_cmd_v_o,
  input  logic            mem_cmd_ready_i,
  input  mem_msg_s        mem_resp_i,
  input  logic            mem_resp_v_i,
  output logic            mem_resp_yumi_o
);

  cache_req_s held_req;
  cache_metadata_s held_metadata;
  logic held_metadata_v;
  logic accept;
  logic evict;
  block_t victim_data;
  tag_t victim_tag;
  logic victim_v;

  uce_control control_inst (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_id_i             (lce_id_i),
    .cache_req_i          (cache_req_i),
    .cache_req_v_i        (cache_req_v_i),
    .cache_req_yumi_o     (cache_req_yumi_o),
    .cache_req_busy_o     (cache_req_busy_o),
    .cache_req_complete_o (cache_req_complete_o),
    .held_req_i           (held_req),
    .held_metadata_i      (held_metadata),
    .held_metadata_v_i    (held_metadata_v),
    .accept_o             (accept),
    .evict_o              (evict),
    .victim_data_i        (victim_data),
    .victim_tag_i         (victim_tag),
    .victim_v_i           (victim_v),
    .credits_full_i       (cache_req_credits_full_o),
    .tag_mem_pkt_o        (tag_mem_pkt_o),
    .tag_mem_pkt_v_o      (tag_mem_pkt_v_o),
    .data_mem_pkt_o       (data_mem_pkt_o),
    .data_mem_pkt_v_o     (data_mem_pkt_v_o),
    .stat_mem_pkt_o       (stat_mem_pkt_o),
    .stat_mem_pkt_v_o     (stat_mem_pkt_v_o),
    .mem_cmd_o            (mem_cmd_o),
    .mem_cmd_v_o          (mem_cmd_v_o),
    .mem_cmd_ready_i      (mem_cmd_ready_i),
    .mem_resp_i           (mem_resp_i),
    .mem_resp_v_i         (mem_resp_v_i),
    .mem_resp_yumi_o      (mem_resp_yumi_o)
  );

  uce_request_latch request_latch_inst (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .cache_req_i        (cache_req_i),
    .cache_metadata_i   (cache_metadata_i),
    .cache_metadata_v_i (cache_metadata_v_i),
    .accept_i           (accept),
    .complete_i         (cache_req_complete_o),
    .req_o              (held_req),
    .metadata_o         (held_metadata),
    .metadata_v_o       (held_metadata_v)
  );

  uce_credit_counter credit_counter_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_sent_i      (mem_cmd_v_o),
    .resp_consumed_i (mem_resp_yumi_o),
    .full_o          (cache_req_credits_full_o),
    .empty_o         (cache_req_credits_empty_o)
  );

  uce_dirty_capture dirty_capture_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .evict_i       (evict),
    .data_mem_i    (data_mem_i),
    .tag_mem_i     (tag_mem_i),
    .victim_data_o (victim_data),
    .victim_tag_o  (victim_tag),
    .victim_v_o    (victim_v)
  );

endmodule

//--- verification/uce_clock_gen.sv
`timescale 1ns/1ns

module uce_clock_gen
(
  output logic clk_o,
  output logic reset_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #2 clk_o = ~clk_o;
  end

  // reset is released just after an edge so the DUT sees a clean low
  initial
  begin
    reset_o = 1'b1;
    repeat (16)
      @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

//--- verification/uce_tb.sv
`timescale 1ns/1ns

`include "uce_settings.svh"

module uce_tb
  import uce_pkg::*;
();

  localparam int timeout_cycles = 200;
  localparam int num_entries = 6;
  localparam int offset_bits = $clog2(`UCE_BLOCK_WIDTH / 8);
  localparam int index_bits = $clog2(`UCE_SETS);

  typedef struct packed {
    cache_req_type_e req_type;
    paddr_t addr;
    logic [2:0] size;
    dword_t data;
    way_t way;
    logic dirty;
    block_t resp_data;
    tag_t victim_tag;
    block_t victim_data;
  } stim_entry_s;

  logic clk;
  logic reset;
  lce_id_t lce_id;
  cache_req_s cache_req;
  logic cache_req_v;
  logic cache_req_yumi;
  logic cache_req_busy;
  cache_metadata_s cache_metadata;
  logic cache_metadata_v;
  logic cache_req_complete;
  logic credits_full;
  logic credits_empty;
  tag_mem_pkt_s tag_pkt;
  logic tag_pkt_v;
  tag_t tag_mem;
  data_mem_pkt_s data_pkt;
  logic data_pkt_v;
  block_t data_mem;
  stat_mem_pkt_s stat_pkt;
  logic stat_pkt_v;
  mem_msg_s mem_cmd;
  logic mem_cmd_v;
  logic mem_cmd_ready;
  mem_msg_s mem_resp;
  logic mem_resp_v;
  logic mem_resp_yumi;

  stim_entry_s stim_table [num_entries];
  stim_entry_s cur;
  logic hold_resp;
  mem_msg_s resp_q [$];
  int resp_head;
  logic data_read_seen;
  logic tag_read_seen;

  uce_clock_gen clock_gen_inst (
    .clk_o   (clk),
    .reset_o (reset)
  );

  uce uce_inst (
    .clk_i                     (clk),
    .reset_i                   (reset),
    .lce_id_i                  (lce_id),
    .cache_req_i               (cache_req),
    .cache_req_v_i             (cache_req_v),
    .cache_req_yumi_o          (cache_req_yumi),
    .cache_req_busy_o          (cache_req_busy),
    .cache_metadata_i          (cache_metadata),
    .cache_metadata_v_i        (cache_metadata_v),
    .cache_req_complete_o      (cache_req_complete),
    .cache_req_credits_full_o  (credits_full),
    .cache_req_credits_empty_o (credits_empty),
    .tag_mem_pkt_o             (tag_pkt),
    .tag_mem_pkt_v_o           (tag_pkt_v),
    .tag_mem_i                 (tag_mem),
    .data_mem_pkt_o            (data_pkt),
    .data_mem_pkt_v_o          (data_pkt_v),
    .data_mem_i                (data_mem),
    .stat_mem_pkt_o            (stat_pkt),
    .stat_mem_pkt_v_o          (stat_pkt_v),
    .mem_cmd_o                 (mem_cmd),
    .mem_cmd_v_o               (mem_cmd_v),
    .mem_cmd_ready_i           (mem_cmd_ready),
    .mem_resp_i                (mem_resp),
    .mem_resp_v_i              (mem_resp_v),
    .mem_resp_yumi_o           (mem_resp_yumi)
  );

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare(input string what, input logic [`UCE_BLOCK_WIDTH-1:0] actual,
                         input logic [`UCE_BLOCK_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  // one negedge step of a bounded wait
  task automatic next_cycle(inout int cycles, input string what);
    @(negedge clk);
    cycles++;
    if (cycles > timeout_cycles)
    begin
      $display("timed out at %0t ns waiting for %s", $time, what);
      stop_on_failure();
    end
  endtask

  function automatic stim_entry_s make_entry(input cache_req_type_e req_type, input paddr_t addr,
      input dword_t data, input way_t way, input logic dirty, input block_t resp_data,
      input tag_t victim_tag, input block_t victim_data);
    stim_entry_s e;
    e.req_type = req_type;
    e.addr = addr;
    e.size = 3'd3;
    e.data = data;
    e.way = way;
    e.dirty = dirty;
    e.resp_data = resp_data;
    e.victim_tag = victim_tag;
    e.victim_data = victim_data;
    return e;
  endfunction

  function automatic mem_msg_s reply_for(input mem_msg_s cmd, input block_t fill);
    mem_msg_s resp;
    resp = cmd;
    if (cmd.msg_type inside {e_mem_rd, e_mem_uc_rd})
      resp.data = fill;
    return resp;
  endfunction

  task automatic fill_table();
    stim_table[0] = make_entry(e_uc_store, 32'h0000_1238, 64'hdead_beef_0123_4567,
      1'b0, 1'b0, '0, '0, '0);
    stim_table[1] = make_entry(e_uc_load, 32'h0000_2040, '0, 1'b0, 1'b0,
      128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, '0, '0);
    stim_table[2] = make_entry(e_miss_load, 32'h0001_0054, '0, 1'b1, 1'b0,
      128'ha5a5_0001_5a5a_0002_a5a5_0003_5a5a_0004, '0, '0);
    stim_table[3] = make_entry(e_miss_store, 32'h0002_0068, 64'h1122_3344_5566_7788,
      1'b0, 1'b1, 128'h0bad_f00d_0000_1111_2222_3333_4444_5555,
      25'h00a_bcde, 128'hcafe_babe_1357_9bdf_0246_8ace_feed_face);
    stim_table[4] = make_entry(e_miss_load, 32'h0003_007c, '0, 1'b1, 1'b1,
      128'h9999_8888_7777_6666_5555_4444_3333_2222,
      25'h155_5555, 128'h0f0f_f0f0_3c3c_c3c3_6969_9696_1234_4321);
    stim_table[5] = make_entry(e_uc_store, 32'h0000_3010, 64'h0a0b_0c0d_0e0f_1011,
      1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic check_clear_sweep();
    int cycles;
    int clears;
    cycles = 0;
    clears = 0;
    while (clears < `UCE_SETS)
    begin
      next_cycle(cycles, "the reset clear sweep");
      compare("busy during the sweep", 128'(cache_req_busy), 128'(1));
      compare("yumi during the sweep", 128'(cache_req_yumi), 128'(0));
      if (tag_pkt_v === 1'b1)
      begin
        compare("sweep tag opcode", 128'(tag_pkt.opcode), 128'(e_tag_clear));
        compare("sweep tag index", 128'(tag_pkt.index), 128'(clears));
        compare("sweep stat valid", 128'(stat_pkt_v), 128'(1));
        compare("sweep stat opcode", 128'(stat_pkt.opcode), 128'(e_stat_clear));
        compare("sweep stat index", 128'(stat_pkt.index), 128'(clears));
        clears++;
      end
      else
        compare("stat valid without tag clear", 128'(stat_pkt_v), 128'(0));
    end
    // withdraw the pending request as the FSM reaches ready
    @(posedge clk);
    #1;
    cache_req_v = 1'b0;
    next_cycle(cycles, "the end of the sweep");
    compare("busy after the sweep", 128'(cache_req_busy), 128'(0));
    compare("tag valid after the sweep", 128'(tag_pkt_v), 128'(0));
    compare("stat valid after the sweep", 128'(stat_pkt_v), 128'(0));
    compare("credits empty after the sweep", 128'(credits_empty), 128'(1));
  endtask

  task automatic run_entry(input stim_entry_s e);
    int cycles;
    logic is_miss;
    index_t index;
    paddr_t block_addr;
    paddr_t wb_addr;
    is_miss = e.req_type inside {e_miss_load, e_miss_store};
    index = index_t'(e.addr >> offset_bits);
    block_addr = e.addr & ~paddr_t'((1 << offset_bits) - 1);
    wb_addr = (paddr_t'(e.victim_tag) << (offset_bits + index_bits))
      | (paddr_t'(index) << offset_bits);

    @(posedge clk);
    #1;
    cur = e;
    cache_req.msg_type = e.req_type;
    cache_req.addr = e.addr;
    cache_req.size = e.size;
    cache_req.data = e.data;
    cache_req_v = 1'b1;
    cache_metadata.repl_way = e.way;
    cache_metadata.dirty = e.dirty;
    cache_metadata_v = is_miss;

    cycles = 0;
    do
      next_cycle(cycles, "request acceptance");
    while (cache_req_yumi !== 1'b1);
    compare("complete at accept", 128'(cache_req_complete), 128'(0));
    if (e.req_type == e_uc_store)
    begin
      compare("store command valid", 128'(mem_cmd_v), 128'(1));
      compare("store command type", 128'(mem_cmd.msg_type), 128'(e_mem_uc_wr));
      compare("store command addr", 128'(mem_cmd.addr), 128'(e.addr));
      compare("store command size", 128'(mem_cmd.size), 128'(e.size));
      compare("store command data", 128'(mem_cmd.data), 128'(e.data));
      compare("store command lce id", 128'(mem_cmd.lce_id), 128'(lce_id));
      compare("store tag packet", 128'(tag_pkt_v), 128'(0));
      compare("store data packet", 128'(data_pkt_v), 128'(0));
      compare("store stat packet", 128'(stat_pkt_v), 128'(0));
    end
    else
      compare("command at load accept", 128'(mem_cmd_v), 128'(0));
    @(posedge clk);
    #1;
    cache_req_v = 1'b0;
    cache_metadata_v = 1'b0;
    if (e.req_type == e_uc_store)
      return;

    cycles = 0;
    do
    begin
      next_cycle(cycles, "the read command");
      compare("complete before the read", 128'(cache_req_complete), 128'(0));
    end
    while (mem_cmd_v !== 1'b1);
    compare("read command lce id", 128'(mem_cmd.lce_id), 128'(lce_id));
    if (is_miss)
    begin
      compare("miss read type", 128'(mem_cmd.msg_type), 128'(e_mem_rd));
      compare("miss read addr", 128'(mem_cmd.addr), 128'(block_addr));
      compare("miss read size", 128'(mem_cmd.size), 128'(offset_bits));
      compare("miss read way", 128'(mem_cmd.way), 128'(e.way));
    end
    else
    begin
      compare("uncached read type", 128'(mem_cmd.msg_type), 128'(e_mem_uc_rd));
      compare("uncached read addr", 128'(mem_cmd.addr), 128'(e.addr));
      compare("uncached read size", 128'(mem_cmd.size), 128'(e.size));
    end

    // a dirty victim is read out in the single cycle after the read command
    if (is_miss && e.dirty)
    begin
      next_cycle(cycles, "the eviction");
      compare("evict data valid", 128'(data_pkt_v), 128'(1));
      compare("evict data opcode", 128'(data_pkt.opcode), 128'(e_data_read));
      compare("evict data index", 128'(data_pkt.index), 128'(index));
      compare("evict data way", 128'(data_pkt.way), 128'(e.way));
      compare("evict tag valid", 128'(tag_pkt_v), 128'(1));
      compare("evict tag opcode", 128'(tag_pkt.opcode), 128'(e_tag_read));
      compare("evict tag index", 128'(tag_pkt.index), 128'(index));
      compare("evict tag way", 128'(tag_pkt.way), 128'(e.way));
      compare("evict stat valid", 128'(stat_pkt_v), 128'(1));
      compare("evict stat opcode", 128'(stat_pkt.opcode), 128'(e_stat_clear_dirty));
      compare("evict stat index", 128'(stat_pkt.index), 128'(index));
      compare("evict stat way", 128'(stat_pkt.way), 128'(e.way));
    end

    cycles = 0;
    do
      next_cycle(cycles, "request completion");
    while (cache_req_complete !== 1'b1);
    compare("response yumi", 128'(mem_resp_yumi), 128'(1));
    compare("fill data valid", 128'(data_pkt_v), 128'(1));
    if (is_miss)
    begin
      compare("fill tag valid", 128'(tag_pkt_v), 128'(1));
      compare("fill tag opcode", 128'(tag_pkt.opcode), 128'(e_tag_set_tag));
      compare("fill tag index", 128'(tag_pkt.index), 128'(index));
      compare("fill tag way", 128'(tag_pkt.way), 128'(e.way));
      compare("fill tag", 128'(tag_pkt.tag), 128'(tag_t'(e.addr >> (offset_bits + index_bits))));
      compare("fill data opcode", 128'(data_pkt.opcode), 128'(e_data_write));
      compare("fill data index", 128'(data_pkt.index), 128'(index));
      compare("fill data way", 128'(data_pkt.way), 128'(e.way));
      compare("fill data", data_pkt.data, e.resp_data);
    end
    else
    begin
      compare("uncached tag valid", 128'(tag_pkt_v), 128'(0));
      compare("uncached data opcode", 128'(data_pkt.opcode), 128'(e_data_uncached));
      compare("uncached data", data_pkt.data,
        {e.resp_data[`UCE_DWORD_WIDTH-1:0], e.resp_data[`UCE_DWORD_WIDTH-1:0]});
    end

    if (is_miss && e.dirty)
    begin
      cycles = 0;
      do
        next_cycle(cycles, "the writeback command");
      while (mem_cmd_v !== 1'b1);
      compare("writeback type", 128'(mem_cmd.msg_type), 128'(e_mem_wr));
      compare("writeback addr", 128'(mem_cmd.addr), 128'(wb_addr));
      compare("writeback data", mem_cmd.data, e.victim_data);
    end
  endtask

  task automatic check_credit_limit();
    int cycles;
    int accepted;
    cycles = 0;
    do
      next_cycle(cycles, "credits to drain");
    while (credits_empty !== 1'b1);
    @(posedge clk);
    #1;
    hold_resp = 1'b1;
    cache_req.msg_type = e_uc_store;
    cache_req.addr = 32'h0000_4000;
    cache_req.size = 3'd3;
    cache_req.data = 64'h0f1e_2d3c_4b5a_6978;
    cache_req_v = 1'b1;
    accepted = 0;
    cycles = 0;
    while (accepted < `UCE_MAX_CREDITS)
    begin
      next_cycle(cycles, "stores to use up the credits");
      compare("credits full early", 128'(credits_full), 128'(0));
      if (cache_req_yumi === 1'b1)
      begin
        compare("credit store valid", 128'(mem_cmd_v), 128'(1));
        compare("credit store type", 128'(mem_cmd.msg_type), 128'(e_mem_uc_wr));
        accepted++;
      end
    end
    for (int i = 0; i < 8; i++)
    begin
      next_cycle(cycles, "a cycle with all credits in use");
      compare("credits full", 128'(credits_full), 128'(1));
      compare("credits empty while full", 128'(credits_empty), 128'(0));
      compare("yumi while full", 128'(cache_req_yumi), 128'(0));
      compare("busy while full", 128'(cache_req_busy), 128'(1));
    end
    @(posedge clk);
    #1;
    cache_req_v = 1'b0;
    hold_resp = 1'b0;
    cycles = 0;
    do
      next_cycle(cycles, "credits to return");
    while (credits_empty !== 1'b1);
    compare("credits full after release", 128'(credits_full), 128'(0));
  endtask

  // commands are logged here, and cache memory reads are noted for the next cycle
  always @(negedge clk)
  begin
    data_read_seen = data_pkt_v && (data_pkt.opcode == e_data_read);
    tag_read_seen = tag_pkt_v && (tag_pkt.opcode == e_tag_read);
    if (mem_cmd_v && mem_cmd_ready)
      resp_q.push_back(reply_for(mem_cmd, cur.resp_data));
  end

  initial
  begin
    data_mem = '0;
    tag_mem = '0;
    forever
    begin
      @(posedge clk);
      #1;
      data_mem = (data_read_seen === 1'b1) ? cur.victim_data : '0;
      tag_mem = (tag_read_seen === 1'b1) ? cur.victim_tag : '0;
    end
  end

  initial
  begin
    mem_cmd_ready = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      mem_cmd_ready = ($urandom % 4) != 0;
    end
  end

  initial
  begin
    int delay;
    int cycles;
    mem_resp = '0;
    mem_resp_v = 1'b0;
    resp_head = 0;
    forever
    begin
      @(posedge clk);
      if (!hold_resp && resp_head < resp_q.size())
      begin
        delay = $urandom % 4;
        repeat (delay)
          @(posedge clk);
        #1;
        mem_resp = resp_q[resp_head];
        mem_resp_v = 1'b1;
        cycles = 0;
        do
        begin
          @(negedge clk);
          cycles++;
          if (cycles > timeout_cycles)
          begin
            $display("memory response was never consumed by %0t ns", $time);
            stop_on_failure();
          end
        end
        while (mem_resp_yumi !== 1'b1);
        @(posedge clk);
        #1;
        mem_resp_v = 1'b0;
        resp_head++;
      end
    end
  end

  initial
  begin
    void'($urandom(34178));
    hold_resp = 1'b0;
    lce_id = 4'h9;
    cache_req = '0;
    cache_req.msg_type = e_miss_load;
    cache_req_v = 1'b1;
    cache_metadata = '0;
    cache_metadata_v = 1'b0;
    cur = '0;
    fill_table();

    check_clear_sweep();
    for (int i = 0; i < num_entries; i++)
      run_entry(stim_table[i]);
    check_credit_limit();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
source/uce_pkg.sv
source/uce_request_latch.sv
source/uce_credit_counter.sv
source/uce_dirty_capture.sv
source/uce_control.sv
source/uce.sv
verification/uce_clock_gen.sv
verification/uce_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the uce testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module uce_tb -Mdir "$build_dir" -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vuce_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Result: PASSED" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
